// File: hw/snk_sram_pkg.sv
// ========================================================================
// Shared widths, depth and structs for the sink SRAM controller unit
// SRAM_DEPTH must be a power of two so the FIFO pointers wrap freely
// SIZE_WIDTH must stay wider than CNT_WIDTH for the counter arithmetic
// ========================================================================

package snk_sram_pkg;

        // ================================================================
        // Widths and depth
        // ================================================================

        // One data beat
        localparam int DATA_WIDTH = 64;

        // FIFO storage in beats
        localparam int SRAM_DEPTH = 16;
        localparam int ADDR_WIDTH = $clog2(SRAM_DEPTH);

        // Counters must be able to hold SRAM_DEPTH itself
        localparam int CNT_WIDTH = ADDR_WIDTH + 1;

        // Beat count carried by allocation and drain requests
        localparam int SIZE_WIDTH = 8;

        // ================================================================
        // Shared types
        // ================================================================

        typedef logic [DATA_WIDTH-1:0] beat_t;

        // Single-cycle request strobe with a beat count
        typedef struct packed {
                logic                  req;
                logic [SIZE_WIDTH-1:0] size;
        } size_req_t;

        // Latency bridge debug flags
        typedef struct packed {
                logic pending;
                logic out_valid;
        } bridge_dbg_t;

endpackage

// File: hw/alloc_ctrl.sv
// ========================================================================
// Free-space counter for the producer side
// Requests are strobes with no ready and are always taken
// Producer must never ask for more than the reported free space
// ========================================================================

`timescale 1ns/100ps

module alloc_ctrl import snk_sram_pkg::*; (
        input  logic                 clk,
        input  logic                 rst_n,
        // Space reservation from the producer
        input  size_req_t            alloc,
        // One beat left the unit on the drain side
        input  logic                 release_beat,
        output logic [CNT_WIDTH-1:0] space_free
);

        // Extra headroom bit so a bad request shows up as a wrap
        logic [SIZE_WIDTH:0] next_free;

        // Credit the released beat, then debit the request
        always_comb begin
                next_free = {{(SIZE_WIDTH + 1 - CNT_WIDTH){1'b0}}, space_free};
                next_free = next_free + {{SIZE_WIDTH{1'b0}}, release_beat};
                if (alloc.req) begin
                        next_free = next_free - {1'b0, alloc.size};
                end
        end

        // Whole FIFO is free out of reset
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        space_free <= CNT_WIDTH'(SRAM_DEPTH);
                end else begin
                        space_free <= next_free[CNT_WIDTH-1:0];
                end
        end

        // ================================================================
        // Checks
        // ================================================================

        // Request larger than the space on hand
        a_no_underflow : assert property (
                @(posedge clk) disable iff (!rst_n)
                alloc.req |-> (int'(alloc.size) <= int'(space_free) + int'(release_beat))
        ) else $error("alloc_ctrl: allocation of %0d exceeds free space %0d",
                      alloc.size, space_free);

        // More beats released than were ever reserved
        a_no_overflow : assert property (
                @(posedge clk) disable iff (!rst_n)
                int'(space_free) <= SRAM_DEPTH
        ) else $error("alloc_ctrl: free space %0d above depth", space_free);

endmodule

// File: hw/drain_ctrl.sv
// ========================================================================
// Available-data counter for the consumer side
// Counts beats written and not yet claimed by a drain request
// Beats sitting in the latency bridge are still part of this count
// ========================================================================

`timescale 1ns/100ps

module drain_ctrl import snk_sram_pkg::*; (
        input  logic                 clk,
        input  logic                 rst_n,
        // Fill handshake pulse
        input  logic                 written_beat,
        // Claim from the consumer
        input  size_req_t            drain,
        output logic [CNT_WIDTH-1:0] data_available
);

        // Headroom bit keeps the arithmetic clean before truncation
        logic [SIZE_WIDTH:0] next_avail;

        // One beat in per fill, a whole request out per claim
        always_comb begin
                next_avail = {{(SIZE_WIDTH + 1 - CNT_WIDTH){1'b0}}, data_available};
                next_avail = next_avail + {{SIZE_WIDTH{1'b0}}, written_beat};
                if (drain.req) begin
                        next_avail = next_avail - {1'b0, drain.size};
                end
        end

        // Nothing stored after reset
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        data_available <= '0;
                end else begin
                        data_available <= next_avail[CNT_WIDTH-1:0];
                end
        end

        // ================================================================
        // Checks
        // ================================================================

        // Consumer must only claim what it was told is there
        a_claim_in_range : assert property (
                @(posedge clk) disable iff (!rst_n)
                drain.req |-> (int'(drain.size) <= int'(data_available))
        ) else $error("drain_ctrl: drain of %0d exceeds available %0d",
                      drain.size, data_available);

        // Stored beats never exceed what FIFO plus bridge can hold
        a_avail_bound : assert property (
                @(posedge clk) disable iff (!rst_n)
                int'(data_available) <= SRAM_DEPTH + 2
        ) else $error("drain_ctrl: available count %0d too large", data_available);

endmodule

// File: hw/sync_fifo.sv
// ========================================================================
// Single-clock beat FIFO with a registered read port
// Reads are self-issued whenever data is present and the reader has room
// Read data and its valid arrive one cycle after the read
// ========================================================================

`timescale 1ns/100ps

module sync_fifo import snk_sram_pkg::*; (
        input  logic                 clk,
        input  logic                 rst_n,
        // Write side
        input  logic                 wr_valid,
        output logic                 wr_ready,
        input  beat_t                wr_data,
        // Downstream can take one more read
        input  logic                 room,
        // Read side, one cycle behind the read
        output logic                 rd_data_valid,
        output beat_t                rd_data,
        output logic [CNT_WIDTH-1:0] count
);

        // Storage array, no reset
        beat_t mem [SRAM_DEPTH];

        logic [ADDR_WIDTH-1:0] wr_ptr;
        logic [ADDR_WIDTH-1:0] rd_ptr;
        logic                  wr_fire;
        logic                  rd_en;

        // ================================================================
        // Handshakes
        // ================================================================

        // Full exactly at depth
        assign wr_ready = (count != CNT_WIDTH'(SRAM_DEPTH));
        assign wr_fire  = wr_valid & wr_ready;

        // Self-issued read
        assign rd_en    = (count != '0) & room;

        // ================================================================
        // Memory
        // ================================================================

        always_ff @(posedge clk) begin
                if (wr_fire) begin
                        mem[wr_ptr] <= wr_data;
                end
        end

        // Registered read port
        always_ff @(posedge clk) begin
                if (rd_en) begin
                        rd_data <= mem[rd_ptr];
                end
        end

        // ================================================================
        // Pointers, occupancy and read valid
        // ================================================================

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        wr_ptr        <= '0;
                        rd_ptr        <= '0;
                        count         <= '0;
                        rd_data_valid <= 1'b0;
                end else begin
                        // Power-of-two depth, pointers wrap on their own
                        if (wr_fire) begin
                                wr_ptr <= wr_ptr + 1'b1;
                        end
                        if (rd_en) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                        case ({wr_fire, rd_en})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                        rd_data_valid <= rd_en;
                end
        end

        // ================================================================
        // Checks
        // ================================================================

        // Pointer distance tracks occupancy, a write while full would break it
        a_ptr_count : assert property (
                @(posedge clk) disable iff (!rst_n)
                (wr_ptr - rd_ptr) == count[ADDR_WIDTH-1:0]
        ) else $error("sync_fifo: pointers and count disagree");

        a_count_bound : assert property (
                @(posedge clk) disable iff (!rst_n)
                int'(count) <= SRAM_DEPTH
        ) else $error("sync_fifo: count %0d above depth", count);

endmodule

// File: hw/latency_bridge.sv
// ========================================================================
// Two-entry skid queue behind a one-cycle-latency read port
// Input has no ready, the source may only read while room is high
// Room looks at this cycle's pop, so it is combinational from m_ready
// ========================================================================

`timescale 1ns/100ps

module latency_bridge import snk_sram_pkg::*; (
        input  logic        clk,
        input  logic        rst_n,
        // Read data from the FIFO, always captured
        input  logic        s_valid,
        input  beat_t       s_data,
        // Next read will fit
        output logic        room,
        // Output stream
        output logic        m_valid,
        input  logic        m_ready,
        output beat_t       m_data,
        output logic [1:0]  occupancy,
        output bridge_dbg_t dbg
);

        // Two payload slots, no reset
        beat_t slot [2];

        logic       wr_sel;
        logic       rd_sel;
        logic       push;
        logic       pop;
        logic [1:0] occ_next;

        // ================================================================
        // Queue control
        // ================================================================

        // Data in flight is always taken
        assign push    = s_valid;
        assign m_valid = (occupancy != 2'd0);
        assign pop     = m_valid & m_ready;

        // Head stays put until the beat is accepted
        assign m_data  = slot[rd_sel];

        // Occupancy plus the pending read, less the beat leaving now
        always_comb begin
                occ_next = occupancy;
                if (push && !pop) begin
                        occ_next = occupancy + 2'd1;
                end else if (!push && pop) begin
                        occ_next = occupancy - 2'd1;
                end
        end

        // A read issued now lands after this edge, one slot must stay open
        assign room = (occ_next != 2'd2);

        always_ff @(posedge clk) begin
                if (push) begin
                        slot[wr_sel] <= s_data;
                end
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        wr_sel    <= 1'b0;
                        rd_sel    <= 1'b0;
                        occupancy <= 2'd0;
                end else begin
                        if (push) begin
                                wr_sel <= ~wr_sel;
                        end
                        if (pop) begin
                                rd_sel <= ~rd_sel;
                        end
                        occupancy <= occ_next;
                end
        end

        // Debug view
        assign dbg = '{pending: s_valid, out_valid: m_valid};

        // ================================================================
        // Checks
        // ================================================================

        // Room gating one cycle earlier must keep full and arrival apart
        a_no_overflow : assert property (
                @(posedge clk) disable iff (!rst_n)
                s_valid |-> (occupancy != 2'd2)
        ) else $error("latency_bridge: read data arrived while full");

endmodule

// File: hw/snk_sram_controller_unit.sv
// ========================================================================
// Single-channel sink buffer between network slave and AXI write engine
// Allocation and drain requests are one-cycle strobes without ready
// Free space is reported two cycles after the event, data one cycle
// ========================================================================

`timescale 1ns/100ps

module snk_sram_controller_unit import snk_sram_pkg::*; (
        input  logic                 clk,
        input  logic                 rst_n,

        // ================================================================
        // Fill side, network slave
        // ================================================================
        input  size_req_t            fill_alloc,
        output logic [CNT_WIDTH-1:0] fill_space_free,
        input  logic                 fill_valid,
        output logic                 fill_ready,
        input  beat_t                fill_data,

        // ================================================================
        // Drain side, AXI write engine
        // ================================================================
        input  size_req_t            drain,
        output logic [CNT_WIDTH-1:0] drain_data_avail,
        output logic                 drain_valid,
        input  logic                 drain_ready,
        output beat_t                drain_data,

        output bridge_dbg_t          dbg
);

        // Handshake pulses for the accounting
        logic                 fill_fire;
        logic                 drain_fire;

        logic [CNT_WIDTH-1:0] space_free_cnt;

        // FIFO to bridge
        logic                 fifo_rd_valid;
        beat_t                fifo_rd_data;
        logic                 bridge_room;

        // Status
        logic [CNT_WIDTH-1:0] fifo_count;
        logic [1:0]           bridge_occupancy;

        assign fill_fire  = fill_valid & fill_ready;
        assign drain_fire = drain_valid & drain_ready;

        // Space is returned only when a beat leaves the unit
        alloc_ctrl u_alloc_ctrl (
                .clk          (clk),
                .rst_n        (rst_n),
                .alloc        (fill_alloc),
                .release_beat (drain_fire),
                .space_free   (space_free_cnt)
        );

        // Bridge beats stay in this count, they were counted on write
        drain_ctrl u_drain_ctrl (
                .clk            (clk),
                .rst_n          (rst_n),
                .written_beat   (fill_fire),
                .drain          (drain),
                .data_available (drain_data_avail)
        );

        sync_fifo u_fifo (
                .clk           (clk),
                .rst_n         (rst_n),
                .wr_valid      (fill_valid),
                .wr_ready      (fill_ready),
                .wr_data       (fill_data),
                .room          (bridge_room),
                .rd_data_valid (fifo_rd_valid),
                .rd_data       (fifo_rd_data),
                .count         (fifo_count)
        );

        latency_bridge u_bridge (
                .clk       (clk),
                .rst_n     (rst_n),
                .s_valid   (fifo_rd_valid),
                .s_data    (fifo_rd_data),
                .room      (bridge_room),
                .m_valid   (drain_valid),
                .m_ready   (drain_ready),
                .m_data    (drain_data),
                .occupancy (bridge_occupancy),
                .dbg       (dbg)
        );

        // Output register keeps the producer off the counter logic
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        fill_space_free <= CNT_WIDTH'(SRAM_DEPTH);
                end else begin
                        fill_space_free <= space_free_cnt;
                end
        end

        // FIFO, read in flight and bridge never hold more than depth plus two
        a_storage_bound : assert property (
                @(posedge clk) disable iff (!rst_n)
                int'(fifo_count) + int'(fifo_rd_valid) + int'(bridge_occupancy)
                        <= SRAM_DEPTH + 2
        ) else $error("snk_sram_controller_unit: stored beats exceed capacity");

endmodule

// File: verification/tb_snk_sram_controller_unit.sv
// ============================================================================
// Testbench for the sink SRAM controller unit, rows of a test table in order
// Every row drains all of its beats before the next row starts
// Rows must keep allocations within the reported free space
// ============================================================================

`timescale 1ns/100ps

module tb_snk_sram_controller_unit import snk_sram_pkg::*; ();

        // Drain stall patterns
        localparam int STALL_NONE   = 0;
        localparam int STALL_RANDOM = 1;
        localparam int STALL_HOLD   = 2;
        localparam int NUM_TESTS    = 5;

        typedef struct packed {
                int alloc_size;
                int late_alloc;
                int beats;
                int stall;
                int drain_size;
                int exp_space;
                int exp_avail;
        } test_row_t;

        // Alloc, late alloc, beats, stall, drain, expected space, expected avail
        localparam test_row_t ROWS [NUM_TESTS] = '{
                '{4,  0, 4,  STALL_NONE,   4,  16, 0},
                '{8,  0, 6,  STALL_NONE,   4,  14, 2},
                '{8,  0, 10, STALL_RANDOM, 12, 16, 0},
                '{16, 2, 18, STALL_HOLD,   18, 16, 0},
                '{8,  0, 8,  STALL_NONE,   8,  16, 0}
        };

        string names [NUM_TESTS] = '{"ordered_drain", "partial_claim", "random_stall",
                                     "full_backpressure", "refill"};

        logic                 clk;
        logic                 rst_n;
        size_req_t            fill_alloc;
        logic [CNT_WIDTH-1:0] fill_space_free;
        logic                 fill_valid;
        logic                 fill_ready;
        beat_t                fill_data;
        size_req_t            drain;
        logic [CNT_WIDTH-1:0] drain_data_avail;
        logic                 drain_valid;
        logic                 drain_ready;
        beat_t                drain_data;
        bridge_dbg_t          dbg;

        // Scoreboard with write cycle per beat
        beat_t  sb_data [$];
        int     sb_cycle [$];
        int     cycle = 0;
        int     space_model;
        int     avail_model;
        int     checks;
        int     errors;
        // Cycles with a FIFO read in flight, one per beat
        int     pending_cycles;
        integer seed;

        snk_sram_controller_unit dut (.*);

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        always @(posedge clk) cycle <= cycle + 1;

        task automatic check(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
                end
        endtask

        function automatic beat_t next_beat();
                return {$random(seed), $random(seed)};
        endfunction

        function automatic int sum_beats();
                int total;
                total = 0;
                for (int i = 0; i < NUM_TESTS; i++) begin
                        total += ROWS[i].beats;
                end
                return total;
        endfunction

        // Debug flags sampled mid-cycle
        always @(negedge clk) begin
                if (rst_n) begin
                        check(dbg.out_valid, drain_valid, "dbg.out_valid vs drain_valid");
                        if (dbg.pending) begin
                                pending_cycles++;
                        end
                end
        end

        task automatic run_test(input int idx);
                test_row_t row;
                int        accepted;
                int        drained;
                int        wcyc;
                int        errs_before;
                bit        drain_sent;
                bit        late_sent;
                bit        released;
                bit        refill_seen;
                beat_t     cur_data;
                beat_t     exp_data;
                row            = ROWS[idx];
                errs_before    = errors;
                accepted       = 0;
                drained        = 0;
                pending_cycles = 0;
                drain_sent     = 1'b0;
                late_sent      = (row.late_alloc == 0);
                released       = (row.stall != STALL_HOLD);
                refill_seen    = 1'b0;
                cur_data       = next_beat();
                @(posedge clk);
                fill_alloc  <= '{req: 1'b1, size: SIZE_WIDTH'(row.alloc_size)};
                space_model -= row.alloc_size;
                fill_valid  <= 1'b1;
                fill_data   <= cur_data;
                drain_ready <= released;
                while (!(accepted == row.beats && drained == row.beats
                         && drain_sent && late_sent)) begin
                        @(posedge clk);
                        fill_alloc <= '0;
                        drain      <= '0;
                        // Held drain, FIFO plus bridge should be exactly full here
                        if (!released && (accepted == row.beats || (fill_valid && !fill_ready))) begin
                                check(accepted, SRAM_DEPTH + 2, "beats accepted before full");
                                check(fill_ready, 1'b0, "fill_ready when full");
                                released = 1'b1;
                        end else if (released && row.stall == STALL_HOLD && fill_ready) begin
                                refill_seen = 1'b1;
                        end
                        // Handshakes of the cycle that just ended
                        if (fill_valid && fill_ready) begin
                                sb_data.push_back(cur_data);
                                sb_cycle.push_back(cycle);
                                accepted++;
                                avail_model++;
                                cur_data = next_beat();
                        end
                        if (drain_valid && drain_ready) begin
                                if (sb_data.size() == 0) begin
                                        errors++;
                                        $display("Drain beat at %0t with no beat outstanding", $time);
                                end else begin
                                        exp_data = sb_data.pop_front();
                                        wcyc     = sb_cycle.pop_front();
                                        check(drain_data, exp_data, "drain_data");
                                        // Valid two edges after the write, taken one edge later
                                        check(cycle - wcyc >= 3, 1'b1, "fill to drain latency");
                                end
                                drained++;
                                space_model++;
                        end
                        fill_valid <= (accepted < row.beats);
                        fill_data  <= cur_data;
                        if (accepted == row.beats && !drain_sent) begin
                                drain       <= '{req: 1'b1, size: SIZE_WIDTH'(row.drain_size)};
                                avail_model -= row.drain_size;
                                drain_sent  = 1'b1;
                        end
                        // Top-up reservation once enough space came back
                        if (!late_sent && space_model >= row.late_alloc) begin
                                fill_alloc  <= '{req: 1'b1, size: SIZE_WIDTH'(row.late_alloc)};
                                space_model -= row.late_alloc;
                                late_sent   = 1'b1;
                        end
                        case (row.stall)
                                STALL_RANDOM: drain_ready <= (($random(seed) & 32'd1) != 0);
                                STALL_HOLD:   drain_ready <= released;
                                default:      drain_ready <= 1'b1;
                        endcase
                end
                // Two idle cycles for the free-space output register
                @(posedge clk);
                fill_alloc  <= '0;
                drain       <= '0;
                fill_valid  <= 1'b0;
                drain_ready <= 1'b1;
                @(posedge clk);
                @(negedge clk);
                check(fill_space_free, space_model, "fill_space_free vs model");
                check(fill_space_free, row.exp_space, "fill_space_free vs table");
                check(drain_data_avail, avail_model, "drain_data_avail vs model");
                check(drain_data_avail, row.exp_avail, "drain_data_avail vs table");
                check(pending_cycles, row.beats, "dbg.pending cycles vs beats read");
                if (row.stall == STALL_HOLD) begin
                        check(refill_seen, 1'b1, "fill_ready back after release");
                end
                $display("%s done, %0d beats, %0d errors", names[idx], row.beats,
                         errors - errs_before);
        endtask

        initial begin : watchdog
                int limit;
                limit = sum_beats() * 20 + 200;
                repeat (limit) @(posedge clk);
                $display("Timeout, run still busy after %0d cycles", limit);
                $display("TEST RESULT: FAIL");
                $finish;
        end

        initial begin
                seed           = 32'h8bb5;
                checks         = 0;
                errors         = 0;
                pending_cycles = 0;
                space_model    = SRAM_DEPTH;
                avail_model    = 0;
                rst_n       <= 1'b0;
                fill_alloc  <= '0;
                fill_valid  <= 1'b0;
                fill_data   <= '0;
                drain       <= '0;
                drain_ready <= 1'b1;
                repeat (2) @(posedge clk);
                rst_n <= 1'b1;
                @(negedge clk);
                // Values straight out of reset
                check(fill_ready, 1'b1, "fill_ready after reset");
                check(drain_valid, 1'b0, "drain_valid after reset");
                check(dbg, '0, "debug flags after reset");
                check(fill_space_free, SRAM_DEPTH, "fill_space_free after reset");
                check(drain_data_avail, 0, "drain_data_avail after reset");
                for (int i = 0; i < NUM_TESTS; i++) begin
                        run_test(i);
                end
                $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
                if (errors == 0) begin
                        $display("TEST RESULT: PASS");
                end else begin
                        $display("TEST RESULT: FAIL");
                end
                $finish;
        end

endmodule

// File: vlog.f
hw/snk_sram_pkg.sv
hw/alloc_ctrl.sv
hw/drain_ctrl.sv
hw/sync_fifo.sv
hw/latency_bridge.sv
hw/snk_sram_controller_unit.sv
verification/tb_snk_sram_controller_unit.sv

// File: Makefile
# Verilator build and run for the sink SRAM controller unit

VERILATOR ?= verilator
TOP       ?= tb_snk_sram_controller_unit
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
